//--- hdl/alu_isa_pkg.sv
package alu_isa_pkg;

	// datapath word width
	localparam int WORD_W = 32;

	typedef logic [WORD_W-1:0] word_t;

	// five bit opcodes as the cpu decoder emits them
	typedef enum logic [4:0] {
		op_add  = 5'b00011,
		op_sub  = 5'b00100,
		op_shr  = 5'b00101,
		op_shra = 5'b00110,
		op_shl  = 5'b00111,
		op_ror  = 5'b01000,
		op_rol  = 5'b01001,
		op_and  = 5'b01010,
		op_or   = 5'b01011,
		op_mul  = 5'b01111,
		op_div  = 5'b10000,
		op_neg  = 5'b10001,
		op_not  = 5'b10010
	} alu_op_e;

	// product view that single word ops share with hi left at zero
	typedef struct packed {
		word_t hi;
		word_t lo;
	} prod_s;

	// divide view with the remainder on top
	typedef struct packed {
		word_t remainder;
		word_t quotient;
	} div_s;

	typedef union packed {
		prod_s prod;
		div_s  div;
	} alu_result_u;

endpackage

//--- hdl/alu_flow_pkg.sv
package alu_flow_pkg;

	// result credit counter width
	localparam int CREDIT_W = 4;

	typedef logic [CREDIT_W-1:0] credit_t;

	// queue entries, also the upstream credit count after reset
	localparam int OP_DEPTH_DEF = 4;

	// credits granted by downstream after reset
	localparam int RES_CREDITS_DEF = 2;

endpackage

//--- hdl/alu_unit_if.sv
`timescale 1ns/100ps

interface alu_unit_if import alu_isa_pkg::*; ();

	// dispatch side, start is a single cycle pulse
	logic        start;
	alu_op_e     opcode;
	word_t       a;
	word_t       b;

	// completion side, result valid while done is high
	logic        done;
	alu_result_u result;

	modport ctrl (
		output start,
		output opcode,
		output a,
		output b,
		input  done,
		input  result
	);

	modport unit (
		input  start,
		input  opcode,
		input  a,
		input  b,
		output done,
		output result
	);

endinterface

//--- hdl/alu_simple_unit.sv
`timescale 1ns/100ps

module alu_simple_unit import alu_isa_pkg::*; (
	input logic      clock,
	input logic      rst_n,
	alu_unit_if.unit p
);

	// shift and rotate amount
	logic [4:0]  sh;
	// operand a twice, rotates fall out of a plain shift
	logic [63:0] dbl;
	logic [63:0] ror_dbl;
	logic [63:0] rol_dbl;
	word_t       value;
	word_t       lo_q;

	assign sh      = p.b[4:0];
	assign dbl     = {p.a, p.a};
	assign ror_dbl = dbl >> sh;
	assign rol_dbl = dbl << sh;

	always_comb begin
		case (p.opcode)
			op_and:  value = p.a & p.b;
			op_or:   value = p.a | p.b;
			op_add:  value = p.a + p.b;
			op_sub:  value = p.a - p.b;
			// logical, zero fill
			op_shr:  value = p.a >> sh;
			// sign fill
			op_shra: value = $signed(p.a) >>> sh;
			op_shl:  value = p.a << sh;
			// low word after the right shift
			op_ror:  value = ror_dbl[31:0];
			// high word after the left shift
			op_rol:  value = rol_dbl[63:32];
			// unary ops take b
			op_neg:  value = -p.b;
			op_not:  value = ~p.b;
			// undefined codes
			default: value = '0;
		endcase
	end

	// capture on start
	always_ff @(posedge clock) begin
		if (p.start) begin
			lo_q <= value;
		end
	end

	// done one cycle behind start
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			p.done <= 1'b0;
		end else begin
			p.done <= p.start;
		end
	end

	// single word, upper half zero
	assign p.result = {word_t'(0), lo_q};

endmodule

//--- hdl/booth_mul.sv
`timescale 1ns/100ps

module booth_mul import alu_isa_pkg::*; (
	input logic      clock,
	input logic      rst_n,
	alu_unit_if.unit p
);

	// one guard bit so subtracting the most negative a cannot overflow
	logic [32:0] mcand;
	logic [32:0] acc;
	word_t       mplr;
	logic        q_tail;
	logic [4:0]  step_cnt;
	logic        busy;

	// step operands, fresh values in the start cycle
	logic [32:0] s_acc;
	logic [32:0] s_mcand;
	logic [32:0] s_sum;
	word_t       s_mplr;
	logic        s_tail;

	always_comb begin
		if (p.start) begin
			s_acc   = '0;
			s_mplr  = p.b;
			s_tail  = 1'b0;
			s_mcand = {p.a[31], p.a};
		end else begin
			s_acc   = acc;
			s_mplr  = mplr;
			s_tail  = q_tail;
			s_mcand = mcand;
		end
		// recode current bit pair
		case ({s_mplr[0], s_tail})
			2'b01:   s_sum = s_acc + s_mcand;
			2'b10:   s_sum = s_acc - s_mcand;
			default: s_sum = s_acc;
		endcase
	end

	// first step taken while loading, arithmetic shift right
	always_ff @(posedge clock) begin
		if (p.start || busy) begin
			{acc, mplr, q_tail} <= {s_sum[32], s_sum, s_mplr};
			mcand <= s_mcand;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			busy     <= 1'b0;
			step_cnt <= '0;
			p.done   <= 1'b0;
		end else begin
			// step 32 lands with done
			p.done <= busy && (step_cnt == 5'd31);
			if (p.start) begin
				busy     <= 1'b1;
				step_cnt <= 5'd1;
			end else if (busy) begin
				step_cnt <= step_cnt + 5'd1;
				if (step_cnt == 5'd31) begin
					busy <= 1'b0;
				end
			end
		end
	end

	// signed product, guard bit is only sign extension
	assign p.result = {acc[31:0], mplr};

endmodule

//--- hdl/restoring_div.sv
`timescale 1ns/100ps

module restoring_div import alu_isa_pkg::*; (
	input logic      clock,
	input logic      rst_n,
	alu_unit_if.unit p
);

	// partial remainder, dividend/quotient shifter, divisor
	word_t       rem_q;
	word_t       quo_q;
	word_t       dsr_q;
	logic [4:0]  step_cnt;
	logic        busy;

	word_t       s_rem;
	word_t       s_quo;
	word_t       s_dsr;
	logic [32:0] shifted;
	logic [33:0] trial;

	always_comb begin
		// operands straight from the port on start
		if (p.start) begin
			s_rem = '0;
			s_quo = p.a;
			s_dsr = p.b;
		end else begin
			s_rem = rem_q;
			s_quo = quo_q;
			s_dsr = dsr_q;
		end
		// bring in next dividend bit
		shifted = {s_rem, s_quo[31]};
		// extra top bit is the borrow
		trial = {1'b0, shifted} - {2'b00, s_dsr};
	end

	// borrow means restore, otherwise keep the difference
	always_ff @(posedge clock) begin
		if (p.start || busy) begin
			rem_q <= trial[33] ? shifted[31:0] : trial[31:0];
			quo_q <= {s_quo[30:0], ~trial[33]};
			dsr_q <= s_dsr;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			busy     <= 1'b0;
			step_cnt <= '0;
			p.done   <= 1'b0;
		end else begin
			// 32nd quotient bit lands with done
			p.done <= busy && (step_cnt == 5'd31);
			if (p.start) begin
				busy     <= 1'b1;
				step_cnt <= 5'd1;
			end else if (busy) begin
				step_cnt <= step_cnt + 5'd1;
				if (step_cnt == 5'd31) begin
					busy <= 1'b0;
				end
			end
		end
	end

	// zero divisor: all ones quotient, dividend left as remainder
	assign p.result = {rem_q, quo_q};

endmodule

//--- hdl/alu_ctrl.sv
`timescale 1ns/100ps

module alu_ctrl import alu_isa_pkg::*, alu_flow_pkg::*; #(
	parameter int OP_DEPTH    = OP_DEPTH_DEF,
	parameter int RES_CREDITS = RES_CREDITS_DEF
) (
	input  logic        clock,
	input  logic        rst_n,
	input  logic        op_valid,
	input  alu_op_e     op_code,
	input  word_t       op_a,
	input  word_t       op_b,
	output logic        op_credit,
	output logic        res_valid,
	output alu_result_u res_word,
	input  logic        res_credit,
	alu_unit_if.ctrl    simple_p,
	alu_unit_if.ctrl    mul_p,
	alu_unit_if.ctrl    div_p
);

	localparam int PTR_W = (OP_DEPTH > 1) ? $clog2(OP_DEPTH) : 1;
	localparam int CNT_W = $clog2(OP_DEPTH + 1);

	// op queue storage
	alu_op_e          q_op [OP_DEPTH];
	word_t            q_a  [OP_DEPTH];
	word_t            q_b  [OP_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] q_count;

	// busy covers execution and a held result
	logic             busy;
	logic             res_pending;
	logic             dispatch;
	logic             release_res;
	logic             any_done;
	logic             is_mul;
	logic             is_div;
	alu_op_e          head_op;
	alu_op_e          iss_op;
	word_t            iss_a;
	word_t            iss_b;
	alu_result_u      res_hold;
	credit_t          res_credits;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		// wrap, depth need not be a power of two
		return (ptr == PTR_W'(OP_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign head_op     = q_op[rd_ptr];
	assign is_mul      = (head_op == op_mul);
	assign is_div      = (head_op == op_div);
	// one op in flight, nothing new until its result has left
	assign dispatch    = !busy && (q_count != '0);
	assign release_res = res_pending && (res_credits != '0);
	assign any_done    = simple_p.done | mul_p.done | div_p.done;

	// upstream only sends with a credit, so no full check
	always_ff @(posedge clock) begin
		if (op_valid) begin
			q_op[wr_ptr] <= op_code;
			q_a[wr_ptr]  <= op_a;
			q_b[wr_ptr]  <= op_b;
		end
		if (dispatch) begin
			iss_op <= head_op;
			iss_a  <= q_a[rd_ptr];
			iss_b  <= q_b[rd_ptr];
		end
		// only one unit finishes at a time
		if (simple_p.done) begin
			res_hold <= simple_p.result;
		end else if (mul_p.done) begin
			res_hold <= mul_p.result;
		end else if (div_p.done) begin
			res_hold <= div_p.result;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr         <= '0;
			rd_ptr         <= '0;
			q_count        <= '0;
			busy           <= 1'b0;
			res_pending    <= 1'b0;
			res_valid      <= 1'b0;
			op_credit      <= 1'b0;
			simple_p.start <= 1'b0;
			mul_p.start    <= 1'b0;
			div_p.start    <= 1'b0;
			res_credits    <= credit_t'(RES_CREDITS);
		end else begin
			if (op_valid) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (dispatch) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			q_count <= q_count + CNT_W'(op_valid) - CNT_W'(dispatch);
			// credit back and start, both a cycle after the pop
			op_credit      <= dispatch;
			simple_p.start <= dispatch && !is_mul && !is_div;
			mul_p.start    <= dispatch && is_mul;
			div_p.start    <= dispatch && is_div;
			if (dispatch) begin
				busy <= 1'b1;
			end else if (release_res) begin
				busy <= 1'b0;
			end
			// held here while out of result credits
			if (any_done) begin
				res_pending <= 1'b1;
			end else if (release_res) begin
				res_pending <= 1'b0;
			end
			res_valid <= release_res;
			// returned credit in the same cycle still counts
			res_credits <= res_credits - credit_t'(release_res) + credit_t'(res_credit);
		end
	end

	// all units share the issue registers
	assign simple_p.opcode = iss_op;
	assign simple_p.a      = iss_a;
	assign simple_p.b      = iss_b;
	assign mul_p.opcode    = iss_op;
	assign mul_p.a         = iss_a;
	assign mul_p.b         = iss_b;
	assign div_p.opcode    = iss_op;
	assign div_p.a         = iss_a;
	assign div_p.b         = iss_b;

	// stable while res_valid is high
	assign res_word = res_hold;

endmodule

//--- hdl/alu_top.sv
`timescale 1ns/100ps

module alu_top import alu_isa_pkg::*, alu_flow_pkg::*; #(
	parameter int OP_DEPTH    = OP_DEPTH_DEF,
	parameter int RES_CREDITS = RES_CREDITS_DEF
) (
	input  logic    clock,
	input  logic    rst_n,
	input  logic    op_valid,
	input  alu_op_e op_code,
	input  word_t   op_a,
	input  word_t   op_b,
	output logic    op_credit,
	output logic    res_valid,
	output word_t   res_lo,
	output word_t   res_hi,
	input  logic    res_credit
);

	alu_result_u res_word;

	// one link per datapath unit
	alu_unit_if simple_if ();
	alu_unit_if mul_if ();
	alu_unit_if div_if ();

	alu_ctrl #(
		.OP_DEPTH    (OP_DEPTH),
		.RES_CREDITS (RES_CREDITS)
	) alu_ctrl_i (
		.clock      (clock),
		.rst_n      (rst_n),
		.op_valid   (op_valid),
		.op_code    (op_code),
		.op_a       (op_a),
		.op_b       (op_b),
		.op_credit  (op_credit),
		.res_valid  (res_valid),
		.res_word   (res_word),
		.res_credit (res_credit),
		.simple_p   (simple_if.ctrl),
		.mul_p      (mul_if.ctrl),
		.div_p      (div_if.ctrl)
	);

	alu_simple_unit alu_simple_unit_i (
		.clock (clock),
		.rst_n (rst_n),
		.p     (simple_if.unit)
	);

	booth_mul booth_mul_i (
		.clock (clock),
		.rst_n (rst_n),
		.p     (mul_if.unit)
	);

	restoring_div restoring_div_i (
		.clock (clock),
		.rst_n (rst_n),
		.p     (div_if.unit)
	);

	// divide remainder also comes out on hi
	assign res_lo = res_word.prod.lo;
	assign res_hi = res_word.prod.hi;

endmodule

//--- verif/alu_tb.sv
`timescale 1ns/100ps

module alu_tb import alu_isa_pkg::*, alu_flow_pkg::*; ();

	localparam int CLK_PERIOD  = 20;
	localparam int OP_DEPTH    = OP_DEPTH_DEF;
	localparam int RES_CREDITS = RES_CREDITS_DEF;
	// op counts of the directed, multiply, divide, mix, back-pressure and undefined tests
	localparam int N_OPS       = 33 + 22 + 10 + 24 + 10 + 13;
	localparam int HOLD_CYC    = 350;
	localparam int WATCHDOG_NS = (40 * N_OPS + HOLD_CYC + 200) * CLK_PERIOD;
	localparam logic [31:0] SEED      = 32'h807ab612;
	localparam logic [31:0] LFSR_POLY = 32'h80200003;
	localparam alu_op_e ALL_OPS [13] = '{op_and, op_or, op_add, op_sub, op_shr, op_shra,
		op_shl, op_ror, op_rol, op_neg, op_not, op_mul, op_div};
	localparam word_t CORNERS [4] = '{32'h8000_0000, 32'hffff_ffff, 32'h0, 32'h7fff_ffff};

	logic    clock;
	logic    rst_n;
	logic    op_valid;
	alu_op_e op_code;
	word_t   op_a;
	word_t   op_b;
	logic    op_credit;
	logic    res_valid;
	word_t   res_lo;
	word_t   res_hi;
	logic    res_credit;

	// credits held by the testbench on each port
	credit_t     up_credits;
	credit_t     res_avail;
	logic [31:0] stim_lfsr;
	logic [31:0] sink_lfsr;
	logic        hold_credits;
	int          owed;
	int          gap;
	int          n_sent;
	int          n_checked;
	int          n_op_credits;
	string       test_name;
	// expected results in send order
	alu_result_u exp_q [$];
	alu_op_e     op_q [$];
	string       name_q [$];
	alu_result_u mon_exp;
	alu_op_e     mon_op;
	string       mon_name;

	alu_top #(
		.OP_DEPTH    (OP_DEPTH),
		.RES_CREDITS (RES_CREDITS)
	) alu_top_i (
		.clock      (clock),
		.rst_n      (rst_n),
		.op_valid   (op_valid),
		.op_code    (op_code),
		.op_a       (op_a),
		.op_b       (op_b),
		.op_credit  (op_credit),
		.res_valid  (res_valid),
		.res_lo     (res_lo),
		.res_hi     (res_hi),
		.res_credit (res_credit)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	// galois lfsr stepped once per bit taken with the lsb shifted out
	function automatic word_t rand_bits(inout logic [31:0] st, input int n);
		word_t v;
		int    i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v  = {v[30:0], st[0]};
			st = (st >> 1) ^ (st[0] ? LFSR_POLY : 32'h0);
		end
		return v;
	endfunction

	// expected result straight from the operation rules
	function automatic alu_result_u ref_alu(input alu_op_e op, input word_t a, input word_t b);
		alu_result_u r;
		int          sh;
		longint      prod;
		r  = '0;
		sh = int'(b[4:0]);
		case (op)
			op_and:  r.prod.lo = a & b;
			op_or:   r.prod.lo = a | b;
			op_add:  r.prod.lo = a + b;
			op_sub:  r.prod.lo = a - b;
			op_shr:  r.prod.lo = a >> sh;
			op_shra: begin
				r.prod.lo = a >> sh;
				// vacated top bits take the sign
				if (a[31]) begin
					r.prod.lo = r.prod.lo | ~(32'hffff_ffff >> sh);
				end
			end
			op_shl:  r.prod.lo = a << sh;
			op_ror:  r.prod.lo = (a >> sh) | (a << (32 - sh));
			op_rol:  r.prod.lo = (a << sh) | (a >> (32 - sh));
			op_neg:  r.prod.lo = 32'd0 - b;
			op_not:  r.prod.lo = ~b;
			op_mul: begin
				prod = longint'(signed'(a)) * longint'(signed'(b));
				r    = alu_result_u'(prod);
			end
			op_div: begin
				// zero divisor gives all ones and the dividend back as remainder
				r.div.quotient  = (b == 0) ? 32'hffff_ffff : a / b;
				r.div.remainder = (b == 0) ? a : a % b;
			end
			default: r = '0;
		endcase
		return r;
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			$display("Error: %s expected %h actual %h", name, exp, act);
			$display("TEST FAILED");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic check_wide(input string name, input alu_result_u exp, input alu_result_u act);
		if (act !== exp) begin
			$display("Error: %s expected %h actual %h", name, exp, act);
			$display("TEST FAILED");
			$fatal(1, "wide mismatch");
		end
	endtask

	// waits for an upstream credit and drives op_valid for one cycle
	task automatic send_op(input alu_op_e op, input word_t a, input word_t b);
		while (up_credits == 0) begin
			@(posedge clock);
			#1;
		end
		op_valid = 1'b1;
		op_code  = op;
		op_a     = a;
		op_b     = b;
		up_credits--;
		exp_q.push_back(ref_alu(op, a, b));
		op_q.push_back(op);
		name_q.push_back($sformatf("%s opcode %b a %h b %h", test_name, op, a, b));
		n_sent++;
		@(posedge clock);
		#1;
		op_valid = 1'b0;
	endtask

	task automatic send_random(input int n);
		int      i;
		alu_op_e op;
		word_t   a_v;
		word_t   b_v;
		for (i = 0; i < n; i++) begin
			op  = ALL_OPS[rand_bits(stim_lfsr, 8) % 13];
			a_v = rand_bits(stim_lfsr, 32);
			b_v = rand_bits(stim_lfsr, 32);
			send_op(op, a_v, b_v);
		end
	endtask

	// compare at the falling edge where outputs are stable
	always @(negedge clock) begin
		if (op_credit) begin
			up_credits++;
			n_op_credits++;
		end
		if (res_valid) begin
			if (res_avail == 0) begin
				fail_run("res_valid seen without a granted result credit");
			end else if (exp_q.size() == 0) begin
				fail_run("result arrived with no operation outstanding");
			end else begin
				mon_exp  = exp_q.pop_front();
				mon_op   = op_q.pop_front();
				mon_name = name_q.pop_front();
				if (mon_op == op_mul || mon_op == op_div) begin
					check_wide(mon_name, mon_exp, {res_hi, res_lo});
				end else begin
					check_word(mon_name, mon_exp.prod.lo, res_lo);
					check_word({mon_name, " hi"}, 32'h0, res_hi);
				end
				res_avail--;
				owed++;
				n_checked++;
			end
		end
	end

	// sink returns each credit after a random gap unless held
	initial begin
		res_credit = 1'b0;
		sink_lfsr  = SEED;
		owed       = 0;
		gap        = 0;
		forever begin
			@(posedge clock);
			#1;
			res_credit = 1'b0;
			if (owed > 0 && !hold_credits) begin
				if (gap == 0) begin
					res_credit = 1'b1;
					owed--;
					res_avail++;
					gap = int'(rand_bits(sink_lfsr, 2));
				end else begin
					gap--;
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired, results stopped arriving");
		$display("TEST FAILED");
		$fatal(1, "timeout");
	end

	initial begin
		int i;
		int j;
		int pulses;
		clock        = 1'b0;
		rst_n        = 1'b0;
		op_valid     = 1'b0;
		op_code      = op_and;
		op_a         = '0;
		op_b         = '0;
		hold_credits = 1'b0;
		stim_lfsr    = SEED;
		up_credits   = credit_t'(OP_DEPTH);
		res_avail    = credit_t'(RES_CREDITS);
		n_sent       = 0;
		n_checked    = 0;
		n_op_credits = 0;
		test_name    = "reset";
		repeat (4) @(posedge clock);
		#1;
		rst_n = 1'b1;
		if (res_valid !== 1'b0 || op_credit !== 1'b0) begin
			fail_run("res_valid or op_credit not low after reset");
		end
		// eleven single word ops with shifts by 0, 31 and 7
		test_name = "directed";
		for (i = 0; i < 11; i++) begin
			send_op(ALL_OPS[i], 32'h8000_00f1, 32'd0);
			send_op(ALL_OPS[i], 32'h8000_00f1, 32'd31);
			send_op(ALL_OPS[i], 32'h7c3a_5e96, 32'hffff_ffe7);
		end
		test_name = "multiply";
		for (i = 0; i < 4; i++) begin
			for (j = 0; j < 4; j++) begin
				send_op(op_mul, CORNERS[i], CORNERS[j]);
			end
		end
		for (i = 0; i < 6; i++) begin
			send_op(op_mul, rand_bits(stim_lfsr, 32), rand_bits(stim_lfsr, 32));
		end
		// small divisors first, then zero, larger than dividend and one
		test_name = "divide";
		for (i = 0; i < 6; i++) begin
			send_op(op_div, rand_bits(stim_lfsr, 32), rand_bits(stim_lfsr, 16));
		end
		send_op(op_div, 32'hdead_beef, 32'h0);
		send_op(op_div, 32'h0000_0005, 32'h0);
		send_op(op_div, 32'h0000_1234, 32'h8000_0000);
		send_op(op_div, 32'hffff_ffff, 32'h1);
		test_name = "random mix";
		send_random(24);
		// drain before stalling the result port
		wait (n_checked == n_sent);
		@(posedge clock);
		#1;
		test_name    = "backpressure";
		hold_credits = 1'b1;
		fork
			send_random(10);
			begin
				repeat (250) @(posedge clock);
				#1;
				pulses = n_op_credits;
				repeat (HOLD_CYC - 250) @(posedge clock);
				#1;
				if (n_op_credits != pulses || up_credits != 0) begin
					fail_run("op_credit kept pulsing while the result port was stalled");
				end
				hold_credits = 1'b0;
			end
		join
		// undefined codes between random neighbors
		test_name = "undefined";
		send_random(5);
		send_op(alu_op_e'(5'b01100), rand_bits(stim_lfsr, 32), rand_bits(stim_lfsr, 32));
		send_random(2);
		send_op(alu_op_e'(5'b11111), rand_bits(stim_lfsr, 32), rand_bits(stim_lfsr, 32));
		send_random(4);
		wait (n_checked == n_sent);
		repeat (10) @(posedge clock);
		if (n_sent == N_OPS && n_checked == N_OPS && exp_q.size() == 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			fail_run("operation count at the end does not match the test list");
		end
	end

endmodule

//--- compile.f
hdl/alu_isa_pkg.sv
hdl/alu_flow_pkg.sv
hdl/alu_unit_if.sv
hdl/alu_simple_unit.sv
hdl/booth_mul.sv
hdl/restoring_div.sv
hdl/alu_ctrl.sv
hdl/alu_top.sv
verif/alu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the ALU testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing -Wno-fatal --top-module alu_tb -f compile.f -o alu_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/alu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
